//--- common/sync_config.svh
`ifndef SYNC_CONFIG_SVH
`define SYNC_CONFIG_SVH

// one sync base period, in nanoseconds and in clock ticks.
`define SYNC_BASE_NS 19'd500000
`define SYNC_BASE_CNT 18'd5120

`define ADDSUB_LATENCY 6  // default depth of the add/sub pipeline.

`define AXIL_ADDR_W 8

`endif

//--- common/sync_pkg.sv
`include "sync_config.svh"

package sync_pkg;

  // settings handed from the register block to the synchronizer.
  typedef struct packed {
    logic        update;          // one cycle strobe.
    logic [63:0] ecat_sync_time;  // nanoseconds.
  } sync_settings_t;

  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] awaddr;
    logic                    awvalid;
    logic [31:0]             wdata;
    logic [3:0]              wstrb;
    logic                    wvalid;
    logic                    bready;
    logic [`AXIL_ADDR_W-1:0] araddr;
    logic                    arvalid;
    logic                    rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        arready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axil_rsp_t;

  typedef enum logic [`AXIL_ADDR_W-1:0] {
    REG_CTRL    = 'h00,
    REG_SYNC_LO = 'h04,
    REG_SYNC_HI = 'h08,
    REG_STATUS  = 'h0C,
    REG_TIME_LO = 'h10,
    REG_TIME_HI = 'h14
  } reg_addr_e;

  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } addsub_op_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } resp_e;

  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    SCALE
  } align_state_e;

endpackage

//--- logic/pipe_addsub.sv
`timescale 1ns/100ps
`include "sync_config.svh"

module pipe_addsub #(
  parameter int LATENCY = `ADDSUB_LATENCY
) (
  input  logic                 CLK,
  input  logic                 arst_n,
  input  sync_pkg::addsub_op_e op,
  input  logic [63:0]          a,
  input  logic [63:0]          b,
  output logic signed [64:0]   s
);
  import sync_pkg::*;

  logic signed [64:0] result;
  logic signed [64:0] chain [LATENCY];

  // both operands are unsigned, so one extra bit keeps the sign of a difference.
  assign result = (op == OP_SUB) ? $signed({1'b0, a}) - $signed({1'b0, b})
                                 : $signed({1'b0, a}) + $signed({1'b0, b});

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < LATENCY; i++) begin
        chain[i] <= '0;
      end
    end else begin
      chain[0] <= result;
      for (int i = 1; i < LATENCY; i++) begin
        chain[i] <= chain[i-1];  // a new pair may enter every cycle.
      end
    end
  end

  assign s = chain[LATENCY-1];

endmodule

//--- synchronizer/lap_aligner.sv
`timescale 1ns/100ps
`include "sync_config.svh"

module lap_aligner (
  input  logic        CLK,
  input  logic        arst_n,
  input  logic        start,
  input  logic [63:0] time_ns,
  output logic [63:0] aligned_tick,
  output logic        done
);
  import sync_pkg::*;

  align_state_e state;
  logic [5:0]   bit_cnt;
  logic [19:0]  rem;
  logic [19:0]  rem_shift;
  logic         rem_ge;
  logic [63:0]  work;  // dividend on entry, quotient after the divide.
  logic [17:0]  mult;

  assign rem_shift = {rem[18:0], work[63]};
  assign rem_ge    = rem_shift >= {1'b0, `SYNC_BASE_NS};

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state   <= IDLE;
      bit_cnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        state   <= DIVIDE;  // a new start restarts a running division.
        bit_cnt <= '0;
      end else begin
        case (state)
          DIVIDE: begin
            bit_cnt <= bit_cnt + 6'd1;
            if (bit_cnt == 6'd63) begin
              state <= SCALE;
            end
          end
          SCALE: begin
            if (mult[17:1] == '0) begin
              state <= IDLE;
              done  <= 1'b1;
            end
          end
          default: begin
            state <= IDLE;
          end
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // restoring divide, then shift-add multiply by the tick count.

  always_ff @(posedge CLK) begin
    if (start) begin
      work         <= time_ns;
      rem          <= '0;
      aligned_tick <= '0;
      mult         <= `SYNC_BASE_CNT;
    end else if (state == DIVIDE) begin
      rem  <= rem_ge ? rem_shift - {1'b0, `SYNC_BASE_NS} : rem_shift;
      work <= {work[62:0], rem_ge};
    end else if (state == SCALE) begin
      if (mult[0]) begin
        aligned_tick <= aligned_tick + work;
      end
      work <= {work[62:0], 1'b0};
      mult <= {1'b0, mult[17:1]};  // stops once no set bit is left.
    end
  end

endmodule

//--- synchronizer/synchronizer.sv
`timescale 1ns/100ps
`include "sync_config.svh"

module synchronizer (
  input  logic                     CLK,
  input  logic                     arst_n,
  input  sync_pkg::sync_settings_t settings,
  input  logic                     ecat_sync,
  output logic [63:0]              sys_time,
  output logic                     sync,
  output logic                     skip_one_assert,
  output logic                     set_pending
);
  import sync_pkg::*;

  logic [2:0]                           sync_tri;
  logic [63:0]                          aligned_tick;
  logic                                 align_done;
  logic                                 aligned_ready;
  logic                                 apply;
  logic [63:0]                          next_sync_time;  // expected grid time.
  logic [63:0]                          a_diff;
  logic [63:0]                          b_diff;
  logic signed [64:0]                   s_diff;
  logic [63:0]                          a_next;
  logic signed [64:0]                   s_next;
  logic signed [18:0]                   sync_time_diff;
  logic [$clog2(`ADDSUB_LATENCY+2)-1:0] diff_cnt;
  logic [$clog2(`ADDSUB_LATENCY+2)-1:0] next_cnt;
  logic [17:0]                          next_sync_cnt;

  lap_aligner u_lap_aligner (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .start        (settings.update),
    .time_ns      (settings.ecat_sync_time),
    .aligned_tick (aligned_tick),
    .done         (align_done)
  );

  pipe_addsub #(.LATENCY(`ADDSUB_LATENCY)) u_sub_diff (
    .CLK    (CLK),
    .arst_n (arst_n),
    .op     (OP_SUB),
    .a      (a_diff),
    .b      (b_diff),
    .s      (s_diff)
  );

  pipe_addsub #(.LATENCY(`ADDSUB_LATENCY)) u_add_next (
    .CLK    (CLK),
    .arst_n (arst_n),
    .op     (OP_ADD),
    .a      (a_next),
    .b      ({46'd0, `SYNC_BASE_CNT}),
    .s      (s_next)
  );

  //////////////////////////////////////////////////
  // sync edge and pending update.

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sync_tri <= '0;
    end else begin
      sync_tri <= {sync_tri[1:0], ecat_sync};  // stage 0 only settles the input.
    end
  end

  assign sync  = sync_tri[1] & ~sync_tri[2];
  assign apply = sync & set_pending & aligned_ready;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      set_pending   <= 1'b0;
      aligned_ready <= 1'b0;
    end else begin
      if (settings.update) begin
        set_pending   <= 1'b1;
        aligned_ready <= 1'b0;
      end else begin
        if (apply) begin
          set_pending <= 1'b0;
        end
        if (align_done) begin
          aligned_ready <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // counter, grid scheduler and drift correction.

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sys_time        <= '0;
      skip_one_assert <= 1'b0;
      next_sync_time  <= '0;
      a_diff          <= '0;
      b_diff          <= '0;
      a_next          <= '0;
      sync_time_diff  <= '0;
      diff_cnt        <= '0;
      next_cnt        <= '0;
      next_sync_cnt   <= '0;
    end else if (sync) begin
      if (apply) begin
        sys_time       <= aligned_tick;
        next_sync_time <= aligned_tick;
        a_diff         <= '0;
        b_diff         <= '0;
        sync_time_diff <= '0;
      end else begin
        a_diff   <= next_sync_time;
        b_diff   <= sys_time + 64'd1;  // the value the counter takes at this pulse.
        sys_time <= sys_time + 64'd1;
      end
      diff_cnt        <= '0;
      next_sync_cnt   <= `SYNC_BASE_CNT / 2;
      skip_one_assert <= 1'b0;
    end else begin
      if (diff_cnt == `ADDSUB_LATENCY + 1) begin
        if (sync_time_diff == '0) begin
          sys_time        <= sys_time + 64'd1;
          skip_one_assert <= 1'b0;
        end else if (sync_time_diff < 19'sd0) begin
          skip_one_assert <= 1'b0;  // counter is ahead, so hold it a cycle.
          sync_time_diff  <= sync_time_diff + 19'sd1;
        end else begin
          sys_time        <= sys_time + 64'd2;
          skip_one_assert <= 1'b1;
          sync_time_diff  <= sync_time_diff - 19'sd1;
        end
      end else begin
        if (diff_cnt == `ADDSUB_LATENCY) begin
          sync_time_diff <= {s_diff[64], s_diff[17:0]};
        end
        diff_cnt        <= diff_cnt + 1'b1;
        sys_time        <= sys_time + 64'd1;
        skip_one_assert <= 1'b0;
      end

      // the grid time moves on half a period after each pulse.
      if (next_sync_cnt == `SYNC_BASE_CNT - 18'd1) begin
        next_sync_cnt <= '0;
        a_next        <= next_sync_time;
        next_cnt      <= '0;
      end else begin
        if (next_cnt == `ADDSUB_LATENCY) begin
          next_sync_time <= s_next[63:0];
          next_cnt       <= next_cnt + 1'b1;
        end else if (next_cnt < `ADDSUB_LATENCY) begin
          next_cnt <= next_cnt + 1'b1;
        end
        next_sync_cnt <= next_sync_cnt + 18'd1;
      end
    end
  end

endmodule

//--- logic/axil_sync_regs.sv
`timescale 1ns/100ps

module axil_sync_regs (
  input  logic                     CLK,
  input  logic                     arst_n,
  input  sync_pkg::axil_req_t      axil_req,
  output sync_pkg::axil_rsp_t      axil_rsp,
  output sync_pkg::sync_settings_t settings,
  input  logic [63:0]              sys_time,
  input  logic                     set_pending
);
  import sync_pkg::*;

  logic        wr_accept;
  logic        rd_accept;
  reg_addr_e   wr_addr;
  reg_addr_e   rd_addr;
  logic [63:0] sync_time;
  logic        update;
  logic        bvalid;
  logic        rvalid;
  resp_e       bresp;
  resp_e       rresp;
  logic [31:0] rdata;
  logic [31:0] time_hi;  // upper time half, caught on a low half read.

  function automatic logic is_mapped(reg_addr_e addr);
    case (addr)
      REG_CTRL, REG_SYNC_LO, REG_SYNC_HI: return 1'b1;
      REG_STATUS, REG_TIME_LO, REG_TIME_HI: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  assign wr_addr   = reg_addr_e'(axil_req.awaddr);
  assign rd_addr   = reg_addr_e'(axil_req.araddr);
  assign wr_accept = axil_req.awvalid & axil_req.wvalid & ~bvalid;
  assign rd_accept = axil_req.arvalid & ~rvalid;

  //////////////////////////////////////////////////
  // write channel.

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sync_time <= '0;
      update    <= 1'b0;
      bvalid    <= 1'b0;
    end else begin
      update <= 1'b0;
      if (wr_accept) begin
        bvalid <= 1'b1;
        case (wr_addr)
          REG_CTRL: begin
            update <= axil_req.wstrb[0] & axil_req.wdata[0];
          end
          REG_SYNC_LO: begin
            for (int i = 0; i < 4; i++) begin
              if (axil_req.wstrb[i]) begin
                sync_time[8*i +: 8] <= axil_req.wdata[8*i +: 8];
              end
            end
          end
          REG_SYNC_HI: begin
            for (int i = 0; i < 4; i++) begin
              if (axil_req.wstrb[i]) begin
                sync_time[32+8*i +: 8] <= axil_req.wdata[8*i +: 8];
              end
            end
          end
          default: begin
            update <= 1'b0;  // read-only and unmapped words keep their state.
          end
        endcase
      end else if (axil_req.bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_accept) begin
      bresp <= is_mapped(wr_addr) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  //////////////////////////////////////////////////
  // read channel.

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      rvalid <= 1'b0;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
    end else if (axil_req.rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (rd_accept) begin
      rresp <= is_mapped(rd_addr) ? RESP_OKAY : RESP_SLVERR;
      case (rd_addr)
        REG_SYNC_LO: rdata <= sync_time[31:0];
        REG_SYNC_HI: rdata <= sync_time[63:32];
        REG_STATUS:  rdata <= {31'd0, set_pending};
        REG_TIME_LO: begin
          rdata   <= sys_time[31:0];
          time_hi <= sys_time[63:32];  // keeps a 64-bit read consistent.
        end
        REG_TIME_HI: rdata <= time_hi;
        default:     rdata <= '0;
      endcase
    end
  end

  assign axil_rsp.awready = wr_accept;
  assign axil_rsp.wready  = wr_accept;
  assign axil_rsp.arready = rd_accept;
  assign axil_rsp.bresp   = bresp;
  assign axil_rsp.bvalid  = bvalid;
  assign axil_rsp.rdata   = rdata;
  assign axil_rsp.rresp   = rresp;
  assign axil_rsp.rvalid  = rvalid;

  assign settings.update         = update;
  assign settings.ecat_sync_time = sync_time;

endmodule

//--- logic/sync_timer_top.sv
`timescale 1ns/100ps

module sync_timer_top (
  input  logic                CLK,
  input  logic                arst_n,
  input  sync_pkg::axil_req_t axil_req,
  output sync_pkg::axil_rsp_t axil_rsp,
  input  logic                ecat_sync,
  output logic [63:0]         sys_time,
  output logic                sync,
  output logic                skip_one_assert
);
  import sync_pkg::*;

  sync_settings_t settings;
  logic           set_pending;

  // host side register block.
  axil_sync_regs u_axil_sync_regs (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp),
    .settings    (settings),
    .sys_time    (sys_time),
    .set_pending (set_pending)
  );

  synchronizer u_synchronizer (
    .CLK             (CLK),
    .arst_n          (arst_n),
    .settings        (settings),
    .ecat_sync       (ecat_sync),
    .sys_time        (sys_time),
    .sync            (sync),
    .skip_one_assert (skip_one_assert),
    .set_pending     (set_pending)
  );

endmodule

//--- testbench/tb_sync_timer.sv
`timescale 1ns/100ps
`include "sync_config.svh"

module tb_sync_timer;
  import sync_pkg::*;

  localparam int     NUM_ITER      = 5;
  localparam int     RUN_PERIODS   = 4;
  localparam int     SYNC_WAIT     = 6000;  // cycles, longer than the longest period.
  localparam longint TOTAL_PERIODS = NUM_ITER * (RUN_PERIODS + 2);
  localparam longint WATCHDOG_NS   = TOTAL_PERIODS * 5120 * 40 + 2_000_000;

  logic        CLK;
  logic        arst_n;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  logic        ecat_sync;
  logic [63:0] sys_time;
  logic        sync;
  logic        skip_one_assert;

  int          pulse_period;
  int          pulse_cnt;
  logic        steps_en;
  logic [63:0] last_time;
  int          exp_corr;
  int          exp_step;
  int          odd_cnt;
  int          periods_seen;
  logic [63:0] sync_model;  // expected content of the sync time registers.

  sync_timer_top DUT (
    .CLK             (CLK),
    .arst_n          (arst_n),
    .axil_req        (axil_req),
    .axil_rsp        (axil_rsp),
    .ecat_sync       (ecat_sync),
    .sys_time        (sys_time),
    .sync            (sync),
    .skip_one_assert (skip_one_assert)
  );

  always #20 CLK = ~CLK;

  //////////////////////////////////////////////////
  // reporting and compares.

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_time(input string name, input logic [63:0] exp, input logic [63:0] got);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s exp=%h got=%h", name, exp, got));
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s exp=%h got=%h", name, exp, got));
    end
  endtask

  task automatic check_resp(input string name, input resp_e exp, input resp_e got);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s exp=%h got=%h", name, exp, got));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s exp=%h got=%h", name, exp, got));
    end
  endtask

  //////////////////////////////////////////////////
  // reference model.

  function automatic logic [63:0] ref_aligned_tick(input logic [63:0] t);
    logic [63:0] lap;
    lap = t / 64'(`SYNC_BASE_NS);
    return lap * 64'(`SYNC_BASE_CNT);
  endfunction

  function automatic int ref_drift(input int d);
    return (d < 0) ? -d : d;
  endfunction

  // a short period makes the counter catch up, a long one makes it wait.
  function automatic int ref_step(input int d);
    return (d < 0) ? 2 : ((d > 0) ? 0 : 1);
  endfunction

  function automatic logic [31:0] merge_strb(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // bus and sync pulse tasks.

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output resp_e resp);
    int waited;
    waited = 0;
    @(posedge CLK);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= strb;
    axil_req.wvalid  <= 1'b1;
    axil_req.bready  <= 1'b1;
    do begin
      @(negedge CLK);
      waited++;
      if (waited > 100) begin
        fail_run("write address and data were never accepted");
      end
    end while (!axil_rsp.awready);
    check_flag("wready", 1'b1, axil_rsp.wready);
    @(posedge CLK);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    @(negedge CLK);
    check_flag("bvalid", 1'b1, axil_rsp.bvalid);
    resp = resp_e'(axil_rsp.bresp);
    @(posedge CLK);
    axil_req.bready <= 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data,
                          output resp_e resp, output logic [63:0] seen_time);
    int waited;
    waited = 0;
    @(posedge CLK);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    axil_req.rready  <= 1'b1;
    do begin
      @(negedge CLK);
      waited++;
      if (waited > 100) begin
        fail_run("read address was never accepted");
      end
    end while (!axil_rsp.arready);
    seen_time = sys_time;  // the value the accepting edge captures.
    @(posedge CLK);
    axil_req.arvalid <= 1'b0;
    @(negedge CLK);
    check_flag("rvalid", 1'b1, axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = resp_e'(axil_rsp.rresp);
    @(posedge CLK);
    axil_req.rready <= 1'b0;
  endtask

  task automatic check_sync_regs();
    logic [31:0] rd;
    resp_e       resp;
    logic [63:0] unused_time;
    bus_read(REG_SYNC_LO, rd, resp, unused_time);
    check_resp("rresp", RESP_OKAY, resp);
    check_reg("sync_lo", sync_model[31:0], rd);
    bus_read(REG_SYNC_HI, rd, resp, unused_time);
    check_resp("rresp", RESP_OKAY, resp);
    check_reg("sync_hi", sync_model[63:32], rd);
  endtask

  task automatic set_pulses(input int period);
    @(negedge CLK);
    pulse_period = period;  // zero stops the pulse train.
  endtask

  task automatic wait_sync();
    int waited;
    waited = 0;
    do begin
      @(negedge CLK);
      waited++;
      if (waited > SYNC_WAIT) begin
        fail_run("no sync pulse was seen in time");
      end
    end while (!sync);
  endtask

  task automatic arm_steps(input int d, input logic [63:0] start_time);
    @(posedge CLK);
    last_time    = start_time;
    exp_corr     = ref_drift(d);
    exp_step     = ref_step(d);
    odd_cnt      = 0;
    periods_seen = 0;
    steps_en     = 1'b1;
  endtask

  always @(posedge CLK) begin
    if (pulse_period > 0) begin
      ecat_sync <= (pulse_cnt < 8);
      pulse_cnt <= (pulse_cnt == pulse_period - 1) ? 0 : pulse_cnt + 1;
    end else begin
      ecat_sync <= 1'b0;
      pulse_cnt <= 0;
    end
  end

  // per cycle step of the counter, with the correction count of each period.
  always @(negedge CLK) begin : step_check
    logic [63:0] step;
    if (steps_en) begin
      step      = sys_time - last_time;
      last_time = sys_time;
      if (step == 64'd1) begin
        check_flag("skip_one_assert", 1'b0, skip_one_assert);
      end else begin
        check_time("sys_time step", 64'(exp_step), step);
        check_flag("skip_one_assert", exp_step == 2, skip_one_assert);
        odd_cnt++;
      end
      if (sync) begin
        if (periods_seen > 0) begin
          check_reg("correction cycles", 32'(exp_corr), 32'(odd_cnt));
        end
        periods_seen++;
        odd_cnt = 0;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped by the watchdog");
  end

  //////////////////////////////////////////////////
  // scenarios.

  initial begin
    logic [31:0] rd;
    logic [31:0] data;
    logic [31:0] lo;
    logic [3:0]  strb;
    logic [7:0]  bad_addr [4];
    logic [63:0] t0;
    logic [63:0] t1;
    logic [63:0] value;
    resp_e       resp;
    int          d;
    void'($urandom(32'hb3ea_30ea));
    CLK          = 1'b0;
    arst_n       <= 1'b0;
    axil_req     <= '0;
    ecat_sync    <= 1'b0;
    pulse_cnt    <= 0;
    pulse_period = 0;
    steps_en     = 1'b0;
    sync_model   = '0;
    bad_addr     = '{8'h18, 8'h1C, 8'h02, 8'hF0};

    repeat (2) @(posedge CLK);
    @(negedge CLK);
    check_flag("sync", 1'b0, sync);
    check_flag("skip_one_assert", 1'b0, skip_one_assert);
    check_flag("bvalid", 1'b0, axil_rsp.bvalid);
    check_flag("rvalid", 1'b0, axil_rsp.rvalid);
    check_time("sys_time", 64'd0, sys_time);
    @(posedge CLK);
    arst_n <= 1'b1;
    bus_read(REG_STATUS, rd, resp, t0);
    check_resp("rresp", RESP_OKAY, resp);
    check_reg("status", 32'd0, rd);

    repeat (12) begin
      data = $urandom;
      strb = 4'($urandom_range(15));
      if ($urandom_range(1) == 1) begin
        bus_write(REG_SYNC_HI, data, strb, resp);
        sync_model[63:32] = merge_strb(sync_model[63:32], data, strb);
      end else begin
        bus_write(REG_SYNC_LO, data, strb, resp);
        sync_model[31:0] = merge_strb(sync_model[31:0], data, strb);
      end
      check_resp("bresp", RESP_OKAY, resp);
      check_sync_regs();
    end
    foreach (bad_addr[i]) begin
      bus_write(bad_addr[i], $urandom, 4'hF, resp);
      check_resp("bresp", RESP_SLVERR, resp);
      bus_read(bad_addr[i], rd, resp, t0);
      check_resp("rresp", RESP_SLVERR, resp);
      check_sync_regs();
    end

    // the first pass runs at the nominal period, later ones drift.
    for (int it = 0; it < NUM_ITER; it++) begin
      d = (it == 0) ? 0 : int'($urandom_range(1000)) - 500;
      sync_model = {$urandom, $urandom};
      bus_write(REG_SYNC_LO, sync_model[31:0], 4'hF, resp);
      check_resp("bresp", RESP_OKAY, resp);
      bus_write(REG_SYNC_HI, sync_model[63:32], 4'hF, resp);
      check_resp("bresp", RESP_OKAY, resp);
      bus_write(REG_CTRL, 32'h1, 4'h1, resp);
      check_resp("bresp", RESP_OKAY, resp);
      bus_read(REG_STATUS, rd, resp, t0);
      check_reg("status", 32'd1, rd);
      repeat (200) @(posedge CLK);  // the divider needs about 80 cycles.
      bus_read(REG_STATUS, rd, resp, t0);
      check_reg("status", 32'd1, rd);

      set_pulses(5120 + d);
      wait_sync();
      @(negedge CLK);
      check_time("sys_time", ref_aligned_tick(sync_model), sys_time);
      arm_steps(d, sys_time);
      bus_read(REG_STATUS, rd, resp, t0);
      check_reg("status", 32'd0, rd);

      bus_read(REG_TIME_LO, lo, resp, t0);
      check_resp("rresp", RESP_OKAY, resp);
      bus_read(REG_TIME_HI, rd, resp, t1);
      check_resp("rresp", RESP_OKAY, resp);
      value = {rd, lo};
      if (value < t0 || value > t1) begin
        fail_run($sformatf("mismatch sys_time read exp=%h..%h got=%h", t0, t1, value));
      end

      repeat (RUN_PERIODS) wait_sync();
      @(posedge CLK);
      steps_en = 1'b0;
      check_reg("periods checked", 32'(RUN_PERIODS), 32'(periods_seen));
      set_pulses(0);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- src.f
+incdir+common
common/sync_pkg.sv
logic/pipe_addsub.sv
synchronizer/lap_aligner.sv
synchronizer/synchronizer.sv
logic/axil_sync_regs.sv
logic/sync_timer_top.sv
testbench/tb_sync_timer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; the log decides pass or fail.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_sync_timer \
  -o sim_tb_sync_timer

./obj_dir/sim_tb_sync_timer | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi

if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
